// ==== memsys_settings.svh ====
/*
  sizing defines for the memory subsystem
  word and address widths, RAM depth, latency field and reset latency
*/
`ifndef MEMSYS_SETTINGS_SVH
`define MEMSYS_SETTINGS_SVH

// data word width
`define MEMSYS_WORD_W 32

// full word address width seen by the CPU
`define MEMSYS_ADDR_W 32

// implemented address bits, 1024 words
`define MEMSYS_RAM_DEPTH_LOG2 10

// width of the latency setting
`define MEMSYS_LAT_W 4

// latency loaded on reset
`define MEMSYS_RESET_LATENCY 2

`endif

// ==== memsysPkg.sv ====
/*
  shared types for the memory subsystem
  word type, RAM and arbiter state enums, CPU and RAM port structs
*/
`include "memsys_settings.svh"

package memsysPkg;

  // one data word or word address
  typedef logic [`MEMSYS_WORD_W-1:0] word_t;

  // state reported by the RAM
  typedef enum logic [1:0] {
    FREE   = 2'd0,
    BUSY   = 2'd1,
    ACCESS = 2'd2,
    ERROR  = 2'd3
  } ramState_t;

  // which port currently owns the RAM
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    IFETCH = 2'd1,
    DREAD  = 2'd2,
    DWRITE = 2'd3
  } grant_t;

  // requests from the CPU side, held until the matching wait drops
  typedef struct packed {
    logic  iRen;
    logic  dRen;
    logic  dWen;
    word_t iAddr;
    word_t dAddr;
    word_t dStore;
  } cpuReq_t;

  // answers back to the CPU side
  typedef struct packed {
    logic  iWait;
    logic  dWait;
    word_t iLoad;
    word_t dLoad;
  } cpuResp_t;

  // controller to RAM
  typedef struct packed {
    logic  ramRen;
    logic  ramWen;
    word_t ramAddr;
    word_t ramStore;
  } ramReq_t;

  // RAM to controller
  typedef struct packed {
    word_t     ramLoad;
    ramState_t ramState;
  } ramResp_t;

endpackage

// ==== ramLatencyConfig.sv ====
/*
  RAM latency configuration register
*/
`timescale 1ns/1ps
`include "memsys_settings.svh"

module ramLatencyConfig (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     cfgWrite,
  input  logic [`MEMSYS_LAT_W-1:0] cfgLatency,
  output logic [`MEMSYS_LAT_W-1:0] latency
);

  logic [`MEMSYS_LAT_W-1:0] latencyReg;
  logic [`MEMSYS_LAT_W-1:0] latencyNext;

  // a strobe replaces the setting, otherwise it holds
  always_comb begin
    latencyNext = latencyReg;
    if (cfgWrite) begin
      latencyNext = cfgLatency;
    end
  end

  // new value is visible the cycle after the strobe
  always_ff @(posedge CLK) begin
    if (reset) begin
      latencyReg <= `MEMSYS_LAT_W'(`MEMSYS_RESET_LATENCY);
    end else begin
      latencyReg <= latencyNext;
    end
  end

  // the RAM samples this when an access starts
  assign latency = latencyReg;

endmodule

// ==== ram.sv ====
/*
  word-addressed RAM with settable access latency
  reports FREE, BUSY, ACCESS or ERROR for each access
*/
`timescale 1ns/1ps
`include "memsys_settings.svh"

module ram (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic [`MEMSYS_LAT_W-1:0] latency,
  input  memsysPkg::ramReq_t       req,
  output memsysPkg::ramResp_t      resp
);

  // storage, contents survive reset
  memsysPkg::word_t mem [0:(1 << `MEMSYS_RAM_DEPTH_LOG2)-1];

  memsysPkg::ramState_t state;
  memsysPkg::ramState_t nextDone;
  memsysPkg::ramState_t finalState;
  logic [`MEMSYS_LAT_W-1:0] count;
  logic                     lastBusy;

  logic reqSeen;
  logic reqInRange;
  logic startAccess;

  // captured request, loaded when the access starts
  logic [`MEMSYS_RAM_DEPTH_LOG2-1:0] addrReg;
  logic [`MEMSYS_RAM_DEPTH_LOG2-1:0] readIdx;
  logic                              wenReg;
  memsysPkg::word_t                  storeReg;
  memsysPkg::word_t                  readWord;

  assign reqSeen = req.ramRen | req.ramWen;

  // any bit above the implemented depth is out of range
  assign reqInRange =
    (req.ramAddr[`MEMSYS_ADDR_W-1:`MEMSYS_RAM_DEPTH_LOG2] == '0);

  assign nextDone    = reqInRange ? memsysPkg::ACCESS : memsysPkg::ERROR;
  assign startAccess = (state == memsysPkg::FREE) && reqSeen;
  assign lastBusy    = (count == {{(`MEMSYS_LAT_W-1){1'b0}}, 1'b1});

  // FREE -> BUSY for L cycles -> ACCESS/ERROR for one cycle -> FREE
  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= memsysPkg::FREE;
      count <= '0;
    end else begin
      case (state)
        memsysPkg::FREE: begin
          if (reqSeen) begin
            count <= latency;
            // zero latency skips BUSY entirely
            if (latency == '0) begin
              state <= nextDone;
            end else begin
              state <= memsysPkg::BUSY;
            end
          end
        end
        memsysPkg::BUSY: begin
          count <= count - 1'b1;
          if (lastBusy) begin
            state <= finalState;
          end
        end
        default: begin
          state <= memsysPkg::FREE;
        end
      endcase
    end
  end

  // latch the request at the start of the access
  always_ff @(posedge CLK) begin
    if (startAccess) begin
      addrReg    <= req.ramAddr[`MEMSYS_RAM_DEPTH_LOG2-1:0];
      wenReg     <= req.ramWen;
      storeReg   <= req.ramStore;
      finalState <= nextDone;
    end
  end

  // read index follows the live address until the access is captured
  assign readIdx = (state == memsysPkg::FREE) ?
                   req.ramAddr[`MEMSYS_RAM_DEPTH_LOG2-1:0] : addrReg;

  // registered read, valid on entry to ACCESS
  always_ff @(posedge CLK) begin
    readWord <= mem[readIdx];
  end

  // writes commit only in the ACCESS cycle, so ERROR drops them
  always_ff @(posedge CLK) begin
    if ((state == memsysPkg::ACCESS) && wenReg) begin
      mem[addrReg] <= storeReg;
    end
  end

  always_comb begin
    resp.ramState = state;
    resp.ramLoad  = (state == memsysPkg::ACCESS) ? readWord : '0;
  end

endmodule

// ==== memoryControl.sv ====
/*
  memory controller joining instruction and data ports to one RAM
  data requests win, a grant holds until the RAM finishes
*/
`timescale 1ns/1ps

module memoryControl (
  input  logic                CLK,
  input  logic                reset,
  input  memsysPkg::cpuReq_t  cpuReq,
  output memsysPkg::cpuResp_t cpuResp,
  output memsysPkg::ramReq_t  ramReq,
  input  memsysPkg::ramResp_t ramResp
);

  memsysPkg::grant_t grant;
  memsysPkg::grant_t grantNext;

  logic ramDone;
  logic dataGrant;
  logic dReq;

  // ERROR also ends the access
  assign ramDone = (ramResp.ramState == memsysPkg::ACCESS) ||
                   (ramResp.ramState == memsysPkg::ERROR);

  assign dReq      = cpuReq.dRen | cpuReq.dWen;
  assign dataGrant = (grant == memsysPkg::DREAD) || (grant == memsysPkg::DWRITE);

  // pick a port only when idle, never preempt
  always_comb begin
    grantNext = grant;
    case (grant)
      memsysPkg::IDLE: begin
        if (cpuReq.dWen) begin
          grantNext = memsysPkg::DWRITE;
        end else if (cpuReq.dRen) begin
          grantNext = memsysPkg::DREAD;
        end else if (cpuReq.iRen) begin
          grantNext = memsysPkg::IFETCH;
        end
      end
      default: begin
        if (ramDone) begin
          grantNext = memsysPkg::IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      grant <= memsysPkg::IDLE;
    end else begin
      grant <= grantNext;
    end
  end

  // steer the granted port onto the RAM
  always_comb begin
    ramReq.ramRen   = (grant == memsysPkg::IFETCH) || (grant == memsysPkg::DREAD);
    ramReq.ramWen   = (grant == memsysPkg::DWRITE);
    ramReq.ramAddr  = (grant == memsysPkg::IFETCH) ? cpuReq.iAddr : cpuReq.dAddr;
    ramReq.ramStore = cpuReq.dStore;
  end

  // wait drops only for the port whose access finishes this cycle
  always_comb begin
    cpuResp.iWait = cpuReq.iRen & ~((grant == memsysPkg::IFETCH) & ramDone);
    cpuResp.dWait = dReq & ~(dataGrant & ramDone);
    cpuResp.iLoad = (grant == memsysPkg::IFETCH) ? ramResp.ramLoad : '0;
    cpuResp.dLoad = (grant == memsysPkg::DREAD) ? ramResp.ramLoad : '0;
  end

endmodule

// ==== memorySystem.sv ====
/*
  memory subsystem top
  controller, RAM and latency register
*/
`timescale 1ns/1ps
`include "memsys_settings.svh"

module memorySystem (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     cfgWrite,
  input  logic [`MEMSYS_LAT_W-1:0] cfgLatency,
  input  memsysPkg::cpuReq_t       cpuReq,
  output memsysPkg::cpuResp_t      cpuResp
);

  logic [`MEMSYS_LAT_W-1:0] latency;
  memsysPkg::ramReq_t       ramReq;
  memsysPkg::ramResp_t      ramResp;

  ramLatencyConfig latCfg0 (
    .CLK        (CLK),
    .reset      (reset),
    .cfgWrite   (cfgWrite),
    .cfgLatency (cfgLatency),
    .latency    (latency)
  );

  memoryControl memCtrl0 (
    .CLK     (CLK),
    .reset   (reset),
    .cpuReq  (cpuReq),
    .cpuResp (cpuResp),
    .ramReq  (ramReq),
    .ramResp (ramResp)
  );

  ram ram0 (
    .CLK     (CLK),
    .reset   (reset),
    .latency (latency),
    .req     (ramReq),
    .resp    (ramResp)
  );

endmodule

// ==== memorySystem_properties.sv ====
/*
  concurrent checks on a request port
  bound into memoryControl and ram by the testbench
*/
`timescale 1ns/1ps

module memorySystemProperties (
  input logic             CLK,
  input logic             reset,
  input logic             rdEn,
  input logic             wrEn,
  input memsysPkg::word_t addr,
  input logic             busy,
  input logic             fetchEn,
  input memsysPkg::word_t fetchAddr,
  input logic             fetchBusy
);

  // read and write are exclusive on one port
  noDualEnable: assert property (
    @(posedge CLK) disable iff (reset)
      !(rdEn && wrEn)
  ) else $error("read and write enables high in the same cycle");

  // address held while the access is still pending
  addrStable: assert property (
    @(posedge CLK) disable iff (reset)
      ((rdEn || wrEn) && busy) |=> $stable(addr)
  ) else $error("request address changed while the port was waiting");

  // same rule for the fetch side
  fetchAddrStable: assert property (
    @(posedge CLK) disable iff (reset)
      (fetchEn && fetchBusy) |=> $stable(fetchAddr)
  ) else $error("fetch address changed while the fetch was waiting");

endmodule

// ==== memorySystem_tb.sv ====
/*
  testbench for the memory subsystem
  seeded random accesses checked against a reference memory, watchdog
*/
`timescale 1ns/1ps
`include "memsys_settings.svh"

module memorySystem_tb;

  localparam int clkPeriod      = 100;
  localparam int driveDelay     = 5;
  localparam int resetCycles    = 5;
  localparam int txnTotal       = 400;
  localparam int watchdogCycles = txnTotal * (15 + 4) + resetCycles;

  logic                     CLK;
  logic                     reset;
  logic                     cfgWrite;
  logic [`MEMSYS_LAT_W-1:0] cfgLatency;
  memsysPkg::cpuReq_t       cpuReq;
  memsysPkg::cpuResp_t      cpuResp;

  int seed = 32'hb278;
  int txnCount;
  int dataErrors;
  int timingErrors;
  int protocolErrors;

  // reference memory, holds only words the testbench wrote
  memsysPkg::word_t model [int unsigned];
  int unsigned      writtenAddrs [$];

  memorySystem dut0 (
    .CLK        (CLK),
    .reset      (reset),
    .cfgWrite   (cfgWrite),
    .cfgLatency (cfgLatency),
    .cpuReq     (cpuReq),
    .cpuResp    (cpuResp)
  );

  bind memoryControl memorySystemProperties ctrlProps (
    .CLK (CLK), .reset (reset),
    .rdEn (cpuReq.dRen), .wrEn (cpuReq.dWen), .addr (cpuReq.dAddr), .busy (cpuResp.dWait),
    .fetchEn (cpuReq.iRen), .fetchAddr (cpuReq.iAddr), .fetchBusy (cpuResp.iWait)
  );

  bind ram memorySystemProperties ramProps (
    .CLK (CLK), .reset (reset),
    .rdEn (req.ramRen), .wrEn (req.ramWen), .addr (req.ramAddr),
    .busy (resp.ramState == memsysPkg::BUSY),
    .fetchEn (1'b0), .fetchAddr ('0), .fetchBusy (1'b0)
  );

  initial begin : clockGen
    CLK = 1'b0;
    forever #(clkPeriod / 2) CLK = ~CLK;
  end

  initial begin : watchdog
    #(watchdogCycles * clkPeriod);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
    $display("test failed");
    $finish;
  end

  task automatic reportWord(input string testName, input memsysPkg::word_t expected,
                            input memsysPkg::word_t actual);
    $display("FAIL %s: expected %h, actual %h", testName, expected, actual);
    dataErrors++;
  endtask

  task automatic reportCycles(input string testName, input int expected, input int actual);
    $display("FAIL %s: expected %0d cycles, actual %0d cycles", testName, expected, actual);
    timingErrors++;
  endtask

  // random word address inside the implemented depth
  function automatic memsysPkg::word_t randomAddr();
    logic [31:0] r;
    r = $random(seed);
    return {{(`MEMSYS_ADDR_W - `MEMSYS_RAM_DEPTH_LOG2){1'b0}}, r[`MEMSYS_RAM_DEPTH_LOG2-1:0]};
  endfunction

  function automatic memsysPkg::word_t pickWritten();
    logic [31:0] r;
    r = $random(seed);
    return writtenAddrs[r % writtenAddrs.size()];
  endfunction

  // drive one request, hold it until its wait is low at a falling edge
  task automatic runAccess(input logic isInstr, input logic isWrite,
                           input memsysPkg::word_t addr, input memsysPkg::word_t store,
                           output memsysPkg::word_t load, output int cycles);
    logic waitLevel;
    waitLevel = 1'b1;
    cycles = 0;
    if (isInstr) begin
      cpuReq.iRen  = 1'b1;
      cpuReq.iAddr = addr;
    end else begin
      cpuReq.dRen   = !isWrite;
      cpuReq.dWen   = isWrite;
      cpuReq.dAddr  = addr;
      cpuReq.dStore = store;
    end
    while (waitLevel) begin
      @(posedge CLK);
      cycles++;
      @(negedge CLK);
      waitLevel = isInstr ? cpuResp.iWait : cpuResp.dWait;
    end
    load = isInstr ? cpuResp.iLoad : cpuResp.dLoad;
    @(posedge CLK);
    #(driveDelay);
    cpuReq.iRen = 1'b0;
    cpuReq.dRen = 1'b0;
    cpuReq.dWen = 1'b0;
    txnCount++;
  endtask

  task automatic writeWord(input memsysPkg::word_t addr, input memsysPkg::word_t data,
                           output int cycles);
    memsysPkg::word_t unused;
    runAccess(1'b0, 1'b1, addr, data, unused, cycles);
    if (!model.exists(addr)) begin
      writtenAddrs.push_back(addr);
    end
    model[addr] = data;
  endtask

  task automatic readCheck(input string testName, input logic isInstr,
                           input memsysPkg::word_t addr);
    memsysPkg::word_t load;
    int cycles;
    runAccess(isInstr, 1'b0, addr, '0, load, cycles);
    // unwritten words have no expected value
    if (model.exists(addr) && load !== model[addr]) begin
      reportWord(testName, model[addr], load);
    end
  endtask

  task automatic setLatency(input int lat);
    cfgWrite   = 1'b1;
    cfgLatency = lat[`MEMSYS_LAT_W-1:0];
    @(posedge CLK);
    #(driveDelay);
    cfgWrite = 1'b0;
  endtask

  // both ports raised together while idle, data must finish first
  task automatic checkPriority(input memsysPkg::word_t fetchAddr,
                               input memsysPkg::word_t dataAddr);
    logic dPending;
    logic iPending;
    logic dDone;
    logic iDone;
    dPending     = 1'b1;
    iPending     = 1'b1;
    cpuReq.iRen  = 1'b1;
    cpuReq.iAddr = fetchAddr;
    cpuReq.dRen  = 1'b1;
    cpuReq.dAddr = dataAddr;
    while (dPending || iPending) begin
      @(negedge CLK);
      dDone = dPending && !cpuResp.dWait;
      iDone = iPending && !cpuResp.iWait;
      if (iDone && dPending) begin
        $display("priority: instruction port completed before the pending data port");
        protocolErrors++;
      end
      if (dDone && cpuResp.dLoad !== model[dataAddr]) begin
        reportWord("priority data", model[dataAddr], cpuResp.dLoad);
      end
      if (iDone && cpuResp.iLoad !== model[fetchAddr]) begin
        reportWord("priority fetch", model[fetchAddr], cpuResp.iLoad);
      end
      @(posedge CLK);
      #(driveDelay);
      if (dDone) begin
        cpuReq.dRen = 1'b0;
        dPending    = 1'b0;
        txnCount++;
      end
      if (iDone) begin
        cpuReq.iRen = 1'b0;
        iPending    = 1'b0;
        txnCount++;
      end
    end
  endtask

  initial begin : stimulus
    memsysPkg::word_t addr;
    memsysPkg::word_t other;
    memsysPkg::word_t data;
    memsysPkg::word_t load;
    logic [31:0]      r;
    int               cycles;
    int               lat;
    reset          = 1'b1;
    cfgWrite       = 1'b0;
    cfgLatency     = '0;
    cpuReq         = '0;
    txnCount       = 0;
    dataErrors     = 0;
    timingErrors   = 0;
    protocolErrors = 0;
    repeat (resetCycles) @(posedge CLK);
    #(driveDelay);
    reset = 1'b0;

    // reset state, idle waits and reset latency timing
    if (cpuResp.iWait !== 1'b0 || cpuResp.dWait !== 1'b0) begin
      $display("after reset a wait level is high with no request (iWait=%b dWait=%b)",
               cpuResp.iWait, cpuResp.dWait);
      protocolErrors++;
    end
    writeWord(randomAddr(), $random(seed), cycles);
    if (cycles != `MEMSYS_RESET_LATENCY + 2) begin
      reportCycles("reset latency", `MEMSYS_RESET_LATENCY + 2, cycles);
    end

    // data write then read, latency changed now and then
    for (int i = 0; i < 120; i++) begin
      if (i % 20 == 19) begin
        setLatency($random(seed) & 15);
      end
      addr = randomAddr();
      writeWord(addr, $random(seed), cycles);
      readCheck("data write read", 1'b0, addr);
    end

    for (int i = 0; i < 60; i++) begin
      readCheck("instruction fetch", 1'b1, pickWritten());
    end

    for (int i = 0; i < 20; i++) begin
      addr  = pickWritten();
      other = pickWritten();
      checkPriority(addr, other);
    end

    // uncontended read timing for each new setting
    for (int i = 0; i < 32; i++) begin
      lat = $random(seed) & 15;
      setLatency(lat);
      addr = pickWritten();
      runAccess(1'b0, 1'b0, addr, '0, load, cycles);
      if (cycles != lat + 2) begin
        reportCycles("latency setting", lat + 2, cycles);
      end
      if (load !== model[addr]) begin
        reportWord("latency data", model[addr], load);
      end
    end

    // out of range aliases of written words
    for (int i = 0; i < 9; i++) begin
      addr  = pickWritten();
      r     = $random(seed);
      other = {r[`MEMSYS_ADDR_W-`MEMSYS_RAM_DEPTH_LOG2-1:0] | 1'b1,
               addr[`MEMSYS_RAM_DEPTH_LOG2-1:0]};
      data  = $random(seed);
      runAccess(1'b0, 1'b1, other, data, load, cycles);
      runAccess(1'b0, 1'b0, other, '0, load, cycles);
      if (load !== '0) begin
        reportWord("out of range read", '0, load);
      end
      readCheck("out of range write dropped", 1'b0, addr);
    end

    $display("accesses %0d, data errors %0d, timing errors %0d, protocol errors %0d",
             txnCount, dataErrors, timingErrors, protocolErrors);
    if (dataErrors + timingErrors + protocolErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== memsys.f ====
+incdir+.
memsysPkg.sv
ramLatencyConfig.sv
ram.sv
memoryControl.sv
memorySystem.sv
memorySystem_properties.sv
memorySystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f memsys.f --top-module memorySystem_tb -o memsysSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/memsysSim 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
